// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_sensor_ctrl \
  -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_sensor_ctrl)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^Result: PASSED$'; then
  exit 0
fi
exit 1

// File: tb.f
verilog/i2c_pkg.sv
verilog/sensor_pkg.sv
verilog/txn_sequencer.sv
verilog/sensor_mode_fsm.sv
verilog/sample_pusher.sv
verilog/sensor_ctrl_top.sv
testbench/i2c_master_bfm.sv
testbench/tb_sensor_ctrl.sv

// File: testbench/i2c_master_bfm.sv
module i2c_master_bfm import i2c_pkg::*; (
  input  logic      i_clk,
  input  logic      i_start,
  input  i2c_byte_t i_addr_bits,
  input  logic      i_data_write_valid,
  input  i2c_byte_t i_data_write_bits,
  input  logic      i_nbytes_valid,
  output logic      o_addr_ready,
  output logic      o_data_write_ready,
  output logic      o_nbytes_ready,
  output logic      o_data_read_valid,
  output i2c_byte_t o_data_read_bits,
  output logic      o_nak,
  output logic      o_ready_in,
  output logic      o_fifo_full
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 2000;

  logic full_next;  // Next transaction runs against a full FIFO

  // FIFO side accepts on about three cycles out of four
  initial begin
    o_ready_in = 1'b0;
    forever begin
      @(posedge i_clk);
      #0.5;
      o_ready_in = ($urandom_range(0, 3) != 0);
    end
  end

  task automatic init_outputs();
    full_next          = 1'b0;
    o_addr_ready       = 1'b1;  // Master idle
    o_data_write_ready = 1'b0;
    o_nbytes_ready     = 1'b0;
    o_data_read_valid  = 1'b0;
    o_data_read_bits   = '0;
    o_nak              = 1'b0;
    o_fifo_full        = 1'b0;
  endtask

  task automatic tick();
    @(posedge i_clk);
    #0.5;
  endtask

  task automatic pause();
    repeat ($urandom_range(1, 3)) tick();
  endtask

  task automatic make_next_txn_full();
    full_next = 1'b1;
  endtask

  // Looks at the current cycle first, so a pulse right after the caller's last tick is kept
  task automatic wait_for(input bit on_start, output bit ok);
    int n;
    n  = 0;
    ok = on_start ? i_start : (i_data_write_valid | i_nbytes_valid);
    while (!ok && n < TIMEOUT_CYCLES) begin
      tick();
      n++;
      ok = on_start ? i_start : (i_data_write_valid | i_nbytes_valid);
    end
  endtask

  task automatic serve_txn(input logic nak, input i2c_byte_t rbyte, output i2c_byte_t addr,
                           output i2c_byte_t ptr, output txn_kind_t kind,
                           output i2c_byte_t data, output string missing);
    bit ok;
    missing = "";
    kind    = REG_READ;
    data    = '0;
    ptr     = '0;
    wait_for(1'b1, ok);
    addr = i_addr_bits;
    if (!ok) begin
      missing = "o_start";
      return;
    end
    o_fifo_full  = full_next;
    full_next    = 1'b0;
    o_addr_ready = 1'b0;
    pause();
    o_data_write_ready = 1'b1;
    wait_for(1'b0, ok);
    if (!ok) begin
      missing = "the register pointer write";
      return;
    end
    ptr                = i_data_write_bits;
    o_data_write_ready = 1'b0;
    if (nak) begin
      o_nak = 1'b1;  // Sensor refuses the pointer
      tick();
      o_nak        = 1'b0;
      o_addr_ready = 1'b1;
      return;
    end
    pause();
    o_data_write_ready = 1'b1;  // Offer both and let the DUT pick
    o_nbytes_ready     = 1'b1;
    wait_for(1'b0, ok);
    if (!ok) begin
      missing = "a data write or a byte count";
      return;
    end
    o_data_write_ready = 1'b0;
    o_nbytes_ready     = 1'b0;
    if (i_data_write_valid) begin
      kind = REG_WRITE;
      data = i_data_write_bits;
    end else begin
      o_data_read_bits  = rbyte;
      o_data_read_valid = 1'b1;
      tick();
      o_data_read_valid = 1'b0;
    end
    pause();
    o_addr_ready = 1'b1;  // Stop sent
  endtask

endmodule

// File: testbench/sensor_trace.txt
# T addr ptr data(-- for a read) nak read_byte | P pushed_byte | F next txn sees FIFO full
# E expected_err | R force reset pulse; bytes in hex, nak 0 or 1
T 9d 00 -- 1 00
T 9d 00 -- 1 00
T 9d 00 -- 0 21
T 9c 09 04 0 00
T 9d 09 -- 0 05
T 9c 09 04 0 00
T 9d 09 -- 0 04
T 9d 00 -- 0 19
P 19
T 9d 0f -- 0 80
P 80
T 9d 00 -- 0 1a
P 1a
F
T 9d 0f -- 0 40
T 9d 00 -- 0 1b
P 1b
T 9d 0f -- 1 00
T 9d 0f -- 1 00
T 9d 0f -- 1 00
E 1
R
T 9d 00 -- 0 22

// File: testbench/tb_sensor_ctrl.sv
module tb_sensor_ctrl import i2c_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 2000;

  logic      clk;
  logic      rst;
  logic      force_rst;
  logic      start;
  logic      addr_ready;
  i2c_byte_t addr_bits;
  logic      addr_valid;
  logic      wr_ready;
  i2c_byte_t wr_bits;
  logic      wr_valid;
  logic      nb_ready;
  i2c_byte_t nb_bits;
  logic      nb_valid;
  logic      rd_valid;
  i2c_byte_t rd_bits;
  logic      nak;
  logic      ready_in;
  logic      fifo_full;
  i2c_byte_t data_in;
  logic      data_in_valid;
  logic      err;
  i2c_byte_t push_q[$];

  sensor_ctrl_top #(
    .ACK_LIMIT    (3),
    .CONFIG_LIMIT (2)
  ) u_dut (
    .i_clk (clk), .i_rst (rst), .i_force_rst (force_rst),
    .o_start (start), .i_addr_ready (addr_ready), .o_addr_bits (addr_bits),
    .o_addr_valid (addr_valid), .i_data_write_ready (wr_ready),
    .o_data_write_bits (wr_bits), .o_data_write_valid (wr_valid),
    .i_nbytes_ready (nb_ready), .o_nbytes_bits (nb_bits), .o_nbytes_valid (nb_valid),
    .i_data_read_valid (rd_valid), .i_data_read_bits (rd_bits), .i_nak (nak),
    .i_ready_in (ready_in), .i_fifo_full (fifo_full), .o_data_in (data_in),
    .o_data_in_valid (data_in_valid), .o_err (err)
  );

  i2c_master_bfm u_bfm (
    .i_clk (clk), .i_start (start), .i_addr_bits (addr_bits),
    .i_data_write_valid (wr_valid), .i_data_write_bits (wr_bits),
    .i_nbytes_valid (nb_valid), .o_addr_ready (addr_ready),
    .o_data_write_ready (wr_ready), .o_nbytes_ready (nb_ready),
    .o_data_read_valid (rd_valid), .o_data_read_bits (rd_bits), .o_nak (nak),
    .o_ready_in (ready_in), .o_fifo_full (fifo_full)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) begin
    if (data_in_valid) push_q.push_back(data_in);  // Every byte the FIFO accepts
    if (start) compare_flag("address valid with o_start", 1'b1, addr_valid);
    if (nb_valid) compare_byte("byte count", 8'h00, nb_bits);  // Master counts from zero
  end

  task automatic tick();
    @(posedge clk);
    #0.5;
  endtask

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic compare_byte(input string name, input i2c_byte_t exp, input i2c_byte_t act);
    if (act !== exp) begin
      $display("Error: %s expected 0x%02h actual 0x%02h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_kind(input string name, input txn_kind_t exp, input txn_kind_t act);
    if (act !== exp) begin
      $display("Error: %s expected %s actual %s", name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic watch_no_start(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      tick();
      if (start) begin
        $display("A transaction started although the controller is in its error state");
        abort_run();
      end
    end
  endtask

  task automatic run_line(input string line, input int num);
    string     tag;
    string     dstr;
    string     name;
    string     missing;
    i2c_byte_t a, p, d, rb;
    i2c_byte_t addr, ptr, data;
    txn_kind_t kind;
    int        nak_ans;
    int        val;
    int        n;
    void'($sscanf(line, "%s", tag));
    name = $sformatf("trace line %0d", num);
    if (tag == "T") begin
      void'($sscanf(line, "%s %h %h %s %d %h", tag, a, p, dstr, nak_ans, rb));
      u_bfm.serve_txn(nak_ans != 0, rb, addr, ptr, kind, data, missing);
      if (missing != "") begin
        $display("Timed out on %s waiting for %s", name, missing);
        abort_run();
      end else begin
        compare_byte({name, " address"}, a, addr);
        compare_byte({name, " pointer"}, p, ptr);
        if (nak_ans == 0 && dstr == "--") begin
          compare_kind({name, " kind"}, REG_READ, kind);
        end else if (nak_ans == 0) begin
          void'($sscanf(dstr, "%h", d));
          compare_kind({name, " kind"}, REG_WRITE, kind);
          compare_byte({name, " data"}, d, data);
        end
      end
    end else if (tag == "P") begin
      void'($sscanf(line, "%s %h", tag, a));
      n = 0;
      while (push_q.size() == 0 && n < TIMEOUT_CYCLES) begin
        tick();
        n++;
      end
      if (push_q.size() == 0) begin
        $display("Timed out on %s waiting for a FIFO push", name);
        abort_run();
      end else begin
        compare_byte({name, " pushed sample"}, a, push_q.pop_front());
      end
    end else if (tag == "F") begin
      u_bfm.make_next_txn_full();
    end else if (tag == "E") begin
      void'($sscanf(line, "%s %d", tag, val));
      n = 0;
      while (err !== (val != 0) && n < TIMEOUT_CYCLES) begin
        tick();
        n++;
      end
      compare_flag({name, " o_err"}, val != 0, err);
      if (val != 0) watch_no_start(200);
    end else if (tag == "R") begin
      force_rst = 1'b1;
      repeat (2) tick();
      force_rst = 1'b0;
      compare_flag({name, " o_err after force reset"}, 1'b0, err);
    end else begin
      $display("Unknown entry %s on %s of the trace", tag, name);
      abort_run();
    end
  endtask

  task automatic play_trace(input int fd);
    string line;
    int    num;
    num = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      num++;
      if (line.len() > 1 && line.substr(0, 0) != "#") run_line(line, num);
    end
    $fclose(fd);
  endtask

  initial begin
    int fd;
    void'($urandom(12261));
    rst       = 1'b1;
    force_rst = 1'b0;
    u_bfm.init_outputs();
    repeat (8) @(posedge clk);
    #0.5;
    rst = 1'b0;
    fd  = $fopen("testbench/sensor_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file testbench/sensor_trace.txt");
      abort_run();
    end else begin
      play_trace(fd);
      if (push_q.size() != 0) begin
        $display("The FIFO received a sample that the trace does not expect");
        abort_run();
      end else begin
        $display("Result: PASSED");
        $finish;
      end
    end
  end

endmodule

// File: verilog/i2c_pkg.sv
package i2c_pkg;

  // One byte on any of the master's data or address lanes
  typedef logic [7:0] i2c_byte_t;

  // REG_READ  = pointer write, then one byte read back
  // REG_WRITE = pointer write, then one data byte
  typedef enum logic [1:0] {
    REG_READ,
    REG_WRITE
  } txn_kind_t;

  // Master counts bytes from zero
  localparam i2c_byte_t NBYTES_ONE = 8'd0;

endpackage

// File: verilog/sample_pusher.sv
module sample_pusher import i2c_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_force_rst,
  input  i2c_byte_t i_sample_byte,
  input  logic      i_sample_valid,
  input  logic      i_ready_in,
  input  logic      i_fifo_full,
  output logic      o_push_busy,
  output i2c_byte_t o_data_in,
  output logic      o_data_in_valid
);

  logic      r_held;
  i2c_byte_t r_byte;

  assign o_push_busy = r_held;
  assign o_data_in   = r_byte;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      r_held          <= 1'b0;
      o_data_in_valid <= 1'b0;
    end else if (i_force_rst) begin
      r_held          <= 1'b0;
      o_data_in_valid <= 1'b0;
    end else begin
      o_data_in_valid <= 1'b0;
      if (!r_held) begin
        r_held <= i_sample_valid;
      end else if (i_fifo_full) begin
        r_held <= 1'b0;  // Drop the byte
      end else if (i_ready_in) begin
        r_held          <= 1'b0;
        o_data_in_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!r_held && i_sample_valid) begin
      r_byte <= i_sample_byte;
    end
  end

endmodule

// File: verilog/sensor_ctrl_top.sv
module sensor_ctrl_top import i2c_pkg::*; #(
  parameter i2c_byte_t   SLAVE_ADDR_READ  = 8'd157,
  parameter i2c_byte_t   SLAVE_ADDR_WRITE = 8'd156,
  parameter int unsigned ACK_LIMIT        = 25,
  parameter int unsigned CONFIG_LIMIT     = 25
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_force_rst,

  output logic      o_start,
  input  logic      i_addr_ready,
  output i2c_byte_t o_addr_bits,
  output logic      o_addr_valid,
  input  logic      i_data_write_ready,
  output i2c_byte_t o_data_write_bits,
  output logic      o_data_write_valid,
  input  logic      i_nbytes_ready,
  output i2c_byte_t o_nbytes_bits,
  output logic      o_nbytes_valid,
  input  logic      i_data_read_valid,
  input  i2c_byte_t i_data_read_bits,
  input  logic      i_nak,

  input  logic      i_ready_in,
  input  logic      i_fifo_full,
  output i2c_byte_t o_data_in,
  output logic      o_data_in_valid,
  output logic      o_err
);

  logic      txn_start;
  txn_kind_t txn_kind;
  i2c_byte_t slave_addr;
  i2c_byte_t reg_ptr;
  i2c_byte_t reg_data;
  logic      txn_done;
  logic      txn_nak;
  i2c_byte_t read_byte;
  i2c_byte_t sample_byte;
  logic      sample_valid;
  logic      push_busy;

  sensor_mode_fsm #(
    .SLAVE_ADDR_READ  (SLAVE_ADDR_READ),
    .SLAVE_ADDR_WRITE (SLAVE_ADDR_WRITE),
    .ACK_LIMIT        (ACK_LIMIT),
    .CONFIG_LIMIT     (CONFIG_LIMIT)
  ) u_mode_fsm (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_force_rst    (i_force_rst),
    .i_txn_done     (txn_done),
    .i_txn_nak      (txn_nak),
    .i_read_byte    (read_byte),
    .i_push_busy    (push_busy),
    .o_txn_start    (txn_start),
    .o_txn_kind     (txn_kind),
    .o_slave_addr   (slave_addr),
    .o_reg_ptr      (reg_ptr),
    .o_reg_data     (reg_data),
    .o_sample_byte  (sample_byte),
    .o_sample_valid (sample_valid),
    .o_err          (o_err)
  );

  txn_sequencer u_sequencer (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .i_force_rst        (i_force_rst),
    .i_txn_start        (txn_start),
    .i_txn_kind         (txn_kind),
    .i_slave_addr       (slave_addr),
    .i_reg_ptr          (reg_ptr),
    .i_reg_data         (reg_data),
    .o_txn_done         (txn_done),
    .o_txn_nak          (txn_nak),
    .o_read_byte        (read_byte),
    .o_start            (o_start),
    .i_addr_ready       (i_addr_ready),
    .o_addr_bits        (o_addr_bits),
    .o_addr_valid       (o_addr_valid),
    .i_data_write_ready (i_data_write_ready),
    .o_data_write_bits  (o_data_write_bits),
    .o_data_write_valid (o_data_write_valid),
    .i_nbytes_ready     (i_nbytes_ready),
    .o_nbytes_bits      (o_nbytes_bits),
    .o_nbytes_valid     (o_nbytes_valid),
    .i_data_read_valid  (i_data_read_valid),
    .i_data_read_bits   (i_data_read_bits),
    .i_nak              (i_nak)
  );

  sample_pusher u_pusher (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_force_rst     (i_force_rst),
    .i_sample_byte   (sample_byte),
    .i_sample_valid  (sample_valid),
    .i_ready_in      (i_ready_in),
    .i_fifo_full     (i_fifo_full),
    .o_push_busy     (push_busy),
    .o_data_in       (o_data_in),
    .o_data_in_valid (o_data_in_valid)
  );

endmodule

// File: verilog/sensor_mode_fsm.sv
module sensor_mode_fsm import i2c_pkg::*, sensor_pkg::*; #(
  parameter i2c_byte_t   SLAVE_ADDR_READ  = 8'd157,
  parameter i2c_byte_t   SLAVE_ADDR_WRITE = 8'd156,
  parameter int unsigned ACK_LIMIT        = 25,
  parameter int unsigned CONFIG_LIMIT     = 25
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_force_rst,
  input  logic      i_txn_done,
  input  logic      i_txn_nak,
  input  i2c_byte_t i_read_byte,
  input  logic      i_push_busy,
  output logic      o_txn_start,
  output txn_kind_t o_txn_kind,
  output i2c_byte_t o_slave_addr,
  output i2c_byte_t o_reg_ptr,
  output i2c_byte_t o_reg_data,
  output i2c_byte_t o_sample_byte,
  output logic      o_sample_valid,
  output logic      o_err
);

  // Counter value at which the next failure trips the error
  localparam logic [7:0] NAK_LAST = 8'(ACK_LIMIT - 1);
  localparam logic [7:0] CFG_LAST = 8'(CONFIG_LIMIT - 1);

  sensor_phase_t r_phase;
  logic [7:0]    r_nak_cnt;
  logic [7:0]    r_cfg_cnt;
  logic          r_frac;     // Next sample read targets the fraction register
  logic          r_pending;  // Transaction wanted but not yet started

  // A fresh sample must reach the pusher before the next read goes out
  assign o_txn_start = r_pending & ~i_push_busy & ~o_sample_valid;
  assign o_err       = (r_phase == PH_NO_RESPOND);

  always_comb begin
    o_txn_kind   = REG_READ;
    o_slave_addr = SLAVE_ADDR_READ;
    o_reg_ptr    = REG_TEMP_INT;
    o_reg_data   = '0;
    case (r_phase)
      PH_CONFIG_WRITE: begin
        o_txn_kind   = REG_WRITE;
        o_slave_addr = SLAVE_ADDR_WRITE;
        o_reg_ptr    = REG_CONFIG_WR;
        o_reg_data   = CONFIG_VALUE;
      end
      PH_CONFIG_READ: o_reg_ptr = REG_CONFIG_RD;
      PH_SAMPLE:      o_reg_ptr = r_frac ? REG_TEMP_FRAC : REG_TEMP_INT;
      default: ;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      r_phase        <= PH_RESET;
      r_nak_cnt      <= '0;
      r_cfg_cnt      <= '0;
      r_frac         <= 1'b0;
      r_pending      <= 1'b0;
      o_sample_valid <= 1'b0;
    end else if (i_force_rst) begin
      r_phase        <= PH_RESET;
      r_nak_cnt      <= '0;
      r_cfg_cnt      <= '0;
      r_frac         <= 1'b0;
      r_pending      <= 1'b0;
      o_sample_valid <= 1'b0;
    end else begin
      o_sample_valid <= 1'b0;
      if (o_txn_start) begin
        r_pending <= 1'b0;
      end

      if (r_phase == PH_RESET) begin
        r_phase   <= PH_PROBE;
        r_pending <= 1'b1;
      end else if (i_txn_done && i_txn_nak) begin
        if (r_nak_cnt == NAK_LAST) begin
          r_phase <= PH_NO_RESPOND;
        end else begin
          r_nak_cnt <= r_nak_cnt + 8'd1;
          r_pending <= 1'b1;  // Same transaction again
        end
      end else if (i_txn_done) begin
        r_nak_cnt <= '0;
        r_pending <= 1'b1;
        case (r_phase)
          PH_PROBE:        r_phase <= PH_CONFIG_WRITE;
          PH_CONFIG_WRITE: r_phase <= PH_CONFIG_READ;
          PH_CONFIG_READ: begin
            if (i_read_byte == CONFIG_VALUE) begin
              r_phase   <= PH_SAMPLE;
              r_cfg_cnt <= '0;
            end else if (r_cfg_cnt == CFG_LAST) begin
              r_phase   <= PH_NO_RESPOND;
              r_pending <= 1'b0;
            end else begin
              r_cfg_cnt <= r_cfg_cnt + 8'd1;
              r_phase   <= PH_CONFIG_WRITE;
            end
          end
          PH_SAMPLE: begin
            o_sample_valid <= 1'b1;
            r_frac         <= ~r_frac;  // Only flips on an acked read
          end
          default: r_pending <= 1'b0;
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_txn_done) begin
      o_sample_byte <= i_read_byte;
    end
  end

endmodule

// File: verilog/sensor_pkg.sv
package sensor_pkg;

  import i2c_pkg::*;

  // Sensor register map
  localparam i2c_byte_t REG_TEMP_INT  = 8'd0;
  localparam i2c_byte_t REG_TEMP_FRAC = 8'd15;
  localparam i2c_byte_t REG_CONFIG_WR = 8'd9;
  localparam i2c_byte_t REG_CONFIG_RD = 8'd9;  // Same as write pointer so readback matches

  localparam i2c_byte_t CONFIG_VALUE = 8'd4;

  // Controller phases
  typedef enum logic [2:0] {
    PH_RESET,
    PH_PROBE,
    PH_CONFIG_WRITE,
    PH_CONFIG_READ,
    PH_SAMPLE,
    PH_NO_RESPOND
  } sensor_phase_t;

endpackage

// File: verilog/txn_sequencer.sv
module txn_sequencer import i2c_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_force_rst,

  input  logic      i_txn_start,
  input  txn_kind_t i_txn_kind,
  input  i2c_byte_t i_slave_addr,
  input  i2c_byte_t i_reg_ptr,
  input  i2c_byte_t i_reg_data,
  output logic      o_txn_done,
  output logic      o_txn_nak,
  output i2c_byte_t o_read_byte,

  output logic      o_start,
  input  logic      i_addr_ready,
  output i2c_byte_t o_addr_bits,
  output logic      o_addr_valid,
  input  logic      i_data_write_ready,
  output i2c_byte_t o_data_write_bits,
  output logic      o_data_write_valid,
  input  logic      i_nbytes_ready,
  output i2c_byte_t o_nbytes_bits,
  output logic      o_nbytes_valid,
  input  logic      i_data_read_valid,
  input  i2c_byte_t i_data_read_bits,
  input  logic      i_nak
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT_ADDR,
    S_LOAD_ADDR,
    S_LOAD_REG,
    S_CHANGE_VALID,
    S_LOAD_DATA,
    S_LOAD_NBYTES,
    S_ANALYSE_DATA
  } step_t;

  step_t r_step;
  logic  r_prev_nak;
  logic  r_prev_wr_ready;
  logic  nak_rise;
  logic  wr_rise;

  assign nak_rise = i_nak & ~r_prev_nak;
  assign wr_rise  = i_data_write_ready & ~r_prev_wr_ready;

  // Request fields are held by the phase machine until txn_done
  assign o_addr_bits       = i_slave_addr;
  assign o_nbytes_bits     = NBYTES_ONE;
  assign o_data_write_bits = (r_step == S_LOAD_DATA) ? i_reg_data : i_reg_ptr;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      r_step             <= S_IDLE;
      r_prev_nak         <= 1'b0;
      r_prev_wr_ready    <= 1'b0;
      o_start            <= 1'b0;
      o_addr_valid       <= 1'b0;
      o_data_write_valid <= 1'b0;
      o_nbytes_valid     <= 1'b0;
      o_txn_done         <= 1'b0;
      o_txn_nak          <= 1'b0;
    end else if (i_force_rst) begin
      r_step             <= S_IDLE;
      r_prev_nak         <= 1'b0;
      r_prev_wr_ready    <= 1'b0;
      o_start            <= 1'b0;
      o_addr_valid       <= 1'b0;
      o_data_write_valid <= 1'b0;
      o_nbytes_valid     <= 1'b0;
      o_txn_done         <= 1'b0;
      o_txn_nak          <= 1'b0;
    end else begin
      r_prev_nak      <= i_nak;
      r_prev_wr_ready <= i_data_write_ready;
      o_txn_done      <= 1'b0;
      o_txn_nak       <= 1'b0;

      if (nak_rise && r_step != S_IDLE) begin
        // Abort from any step
        r_step             <= S_IDLE;
        o_start            <= 1'b0;
        o_addr_valid       <= 1'b0;
        o_data_write_valid <= 1'b0;
        o_nbytes_valid     <= 1'b0;
        o_txn_done         <= 1'b1;
        o_txn_nak          <= 1'b1;
      end else begin
        case (r_step)
          S_IDLE, S_WAIT_ADDR: begin
            if (i_txn_start || r_step == S_WAIT_ADDR) begin
              if (i_addr_ready) begin
                o_start      <= 1'b1;
                o_addr_valid <= 1'b1;
                r_step       <= S_LOAD_ADDR;
              end else begin
                r_step <= S_WAIT_ADDR;
              end
            end
          end
          S_LOAD_ADDR: begin
            o_start <= 1'b0;  // Single-cycle start
            if (wr_rise) begin
              o_data_write_valid <= 1'b1;  // Pointer byte
              r_step             <= S_LOAD_REG;
            end
          end
          S_LOAD_REG: begin
            o_data_write_valid <= 1'b0;
            o_addr_valid       <= 1'b0;
            r_step             <= S_CHANGE_VALID;
          end
          S_CHANGE_VALID: begin
            if (i_txn_kind == REG_WRITE) begin
              if (wr_rise) begin
                o_data_write_valid <= 1'b1;  // Data byte
                r_step             <= S_LOAD_DATA;
              end
            end else if (i_nbytes_ready) begin
              o_nbytes_valid <= 1'b1;
              r_step         <= S_LOAD_NBYTES;
            end
          end
          S_LOAD_DATA: begin
            o_data_write_valid <= 1'b0;
            r_step             <= S_ANALYSE_DATA;
          end
          S_LOAD_NBYTES: begin
            if (i_data_read_valid) begin
              o_nbytes_valid <= 1'b0;
              r_step         <= S_ANALYSE_DATA;
            end
          end
          S_ANALYSE_DATA: begin
            // Master idle again means the stop went out acked
            if (i_addr_ready) begin
              o_txn_done <= 1'b1;
              r_step     <= S_IDLE;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (r_step == S_LOAD_NBYTES && i_data_read_valid) begin
      o_read_byte <= i_data_read_bits;
    end
  end

endmodule
